// ==== verilog/dispatch_pkg.sv ====
// dispatch unit shared definitions
// sizes of the core cluster and FIFO, and the register map seen by each core

`default_nettype none

package dispatch_pkg;

  // cluster size, also the width of a team mask
  localparam int NB_CORES   = 4;

  // number of dispatch entries and the matching pointer width
  localparam int FIFO_DEPTH = 4;
  localparam int PTR_W      = $clog2(FIFO_DEPTH);

  // core bus widths
  localparam int DATA_W     = 32;
  localparam int ADDR_W     = 2;

  // register offsets
  // write pushes a value for the current team
  localparam logic [ADDR_W-1:0] REG_PUSH = 2'd0;
  // write sets the team mask from the low NB_CORES data bits
  localparam logic [ADDR_W-1:0] REG_TEAM = 2'd1;
  // read blocks until a value for this core is available
  localparam logic [ADDR_W-1:0] REG_POP  = 2'd2;

endpackage

`default_nettype wire

// ==== verilog/dispatch_reg_decode.sv ====
// dispatch register decoder
// splits every core's bus access into FIFO writes, pop reads and
// reads of other offsets, purely combinational

`timescale 1ns/1ns
`default_nettype none

module dispatch_reg_decode (
  // core bus side
  input  logic [dispatch_pkg::NB_CORES-1:0]                           core_req_i,
  input  logic [dispatch_pkg::NB_CORES-1:0]                           core_we_i,
  input  logic [dispatch_pkg::NB_CORES-1:0][dispatch_pkg::ADDR_W-1:0] core_addr_i,
  input  logic [dispatch_pkg::NB_CORES-1:0][dispatch_pkg::DATA_W-1:0] core_wdata_i,

  // writes towards the FIFO
  output logic [dispatch_pkg::NB_CORES-1:0]                           w_req_o,
  output logic [dispatch_pkg::NB_CORES-1:0][dispatch_pkg::ADDR_W-1:0] reg_sel_o,
  output logic [dispatch_pkg::NB_CORES-1:0][dispatch_pkg::DATA_W-1:0] w_data_o,

  // reads towards the responders
  output logic [dispatch_pkg::NB_CORES-1:0]                           pop_req_o,
  output logic [dispatch_pkg::NB_CORES-1:0]                           rd_other_o
);

  import dispatch_pkg::*;

  // per-core access classification
  logic [NB_CORES-1:0] is_wr;
  logic [NB_CORES-1:0] is_rd;
  logic [NB_CORES-1:0] addr_mapped_wr;

  always_comb begin
    for (int c = 0; c < NB_CORES; c++) begin
      // split the request by direction
      is_wr[c] = core_req_i[c] & core_we_i[c];
      is_rd[c] = core_req_i[c] & ~core_we_i[c];

      // only push and team registers accept writes
      addr_mapped_wr[c] = (core_addr_i[c] == REG_PUSH) ||
                          (core_addr_i[c] == REG_TEAM);
    end
  end

  always_comb begin
    for (int c = 0; c < NB_CORES; c++) begin
      // writes to REG_POP or unmapped offsets are dropped
      w_req_o[c]   = is_wr[c] & addr_mapped_wr[c];
      reg_sel_o[c] = core_addr_i[c];

      // zero data on idle lanes so the FIFO can OR the lanes together
      if (w_req_o[c]) begin
        w_data_o[c] = core_wdata_i[c];
      end else begin
        w_data_o[c] = '0;
      end

      // a read is either a pop or a read of any other offset
      pop_req_o[c]  = is_rd[c] & (core_addr_i[c] == REG_POP);
      rd_other_o[c] = is_rd[c] & (core_addr_i[c] != REG_POP);
    end
  end

endmodule

`default_nettype wire

// ==== verilog/dispatch_fifo.sv ====
// dispatch FIFO
// shared circular value store with per-entry team status bits and one
// read pointer per core that skips entries not meant for that core

`timescale 1ns/1ns
`default_nettype none

module dispatch_fifo (
  input  logic                                                        clk_i,
  input  logic                                                        rst_ni,

  // writes from the decoder, one lane per core
  input  logic [dispatch_pkg::NB_CORES-1:0]                           w_req_i,
  input  logic [dispatch_pkg::NB_CORES-1:0][dispatch_pkg::ADDR_W-1:0] reg_sel_i,
  input  logic [dispatch_pkg::NB_CORES-1:0][dispatch_pkg::DATA_W-1:0] w_data_i,

  // pop handshake with the responders
  input  logic [dispatch_pkg::NB_CORES-1:0]                           pop_req_i,
  input  logic [dispatch_pkg::NB_CORES-1:0]                           pop_ack_i,
  output logic [dispatch_pkg::NB_CORES-1:0][dispatch_pkg::DATA_W-1:0] dispatch_value_o,
  output logic [dispatch_pkg::NB_CORES-1:0]                           dispatch_event_o
);

  import dispatch_pkg::*;

  // value storage
  logic [FIFO_DEPTH-1:0][DATA_W-1:0]   fifo_q;

  // prepared team mask and per-entry status
  logic [NB_CORES-1:0]                 team_q, team_d;
  logic [FIFO_DEPTH-1:0][NB_CORES-1:0] stat_q, stat_d;
  logic [FIFO_DEPTH-1:0][NB_CORES-1:0] clr_stat;

  // pointers and per-core pop tracking
  logic [PTR_W-1:0]                    wptr_q, wptr_d;
  logic [NB_CORES-1:0][PTR_W-1:0]      rptr_q, rptr_d;
  logic [NB_CORES-1:0]                 in_progr_q, in_progr_d;
  logic [NB_CORES-1:0]                 incr_del_q;

  // OR-reduced write lanes
  logic                                push;
  logic                                team_wr;
  logic [DATA_W-1:0]                   push_data;
  logic [DATA_W-1:0]                   team_data;

  // combine the write lanes of all cores
  always_comb begin
    push      = 1'b0;
    team_wr   = 1'b0;
    push_data = '0;
    team_data = '0;
    for (int c = 0; c < NB_CORES; c++) begin
      if (w_req_i[c] && (reg_sel_i[c] == REG_PUSH)) begin
        push      = 1'b1;
        push_data = push_data | w_data_i[c];
      end
      if (w_req_i[c] && (reg_sel_i[c] == REG_TEAM)) begin
        team_wr   = 1'b1;
        team_data = team_data | w_data_i[c];
      end
    end
  end

  // per-core read side
  always_comb begin
    clr_stat         = '0;
    dispatch_event_o = '0;
    in_progr_d       = in_progr_q;
    rptr_d           = rptr_q;
    for (int c = 0; c < NB_CORES; c++) begin
      dispatch_value_o[c] = fifo_q[rptr_q[c]];

      if (pop_req_i[c] || in_progr_q[c]) begin
        in_progr_d[c] = 1'b1;
        if (stat_q[rptr_q[c]][c]) begin
          // entry at the read pointer is meant for this core
          dispatch_event_o[c] = 1'b1;
        end else if (rptr_q[c] != wptr_q) begin
          // skip foreign entries, stop at the write pointer
          rptr_d[c] = rptr_q[c] + PTR_W'(1);
        end
      end

      // value taken, drop this core's status bit
      if (in_progr_q[c] && pop_ack_i[c]) begin
        in_progr_d[c]            = 1'b0;
        clr_stat[rptr_q[c]][c]   = 1'b1;
      end

      // pointer moves on one cycle after the acknowledge
      if (incr_del_q[c]) begin
        rptr_d[c] = rptr_q[c] + PTR_W'(1);
      end
    end
  end

  // write side and status update
  always_comb begin
    team_d = team_q;
    wptr_d = wptr_q;
    stat_d = stat_q & ~clr_stat;

    if (push) begin
      // new entry takes the prepared team, overwriting any live bits
      stat_d[wptr_q] = team_q;
      wptr_d         = wptr_q + PTR_W'(1);
    end

    // new mask applies to pushes from the next cycle on
    if (team_wr) begin
      team_d = team_data[NB_CORES-1:0];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      team_q     <= '0;
      stat_q     <= '0;
      wptr_q     <= '0;
      rptr_q     <= '0;
      in_progr_q <= '0;
      incr_del_q <= '0;
    end else begin
      team_q     <= team_d;
      stat_q     <= stat_d;
      wptr_q     <= wptr_d;
      rptr_q     <= rptr_d;
      in_progr_q <= in_progr_d;
      incr_del_q <= in_progr_q & pop_ack_i;
    end
  end

  // value storage, written at the write pointer on a push
  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_q[wptr_q] <= push_data;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/dispatch_read_resp.sv ====
// dispatch read responder
// holds one core's pop until the FIFO flags a value, then acknowledges it
// and returns the value; other reads are answered with zero

`timescale 1ns/1ns
`default_nettype none

module dispatch_read_resp (
  input  logic                            clk_i,
  input  logic                            rst_ni,

  // read requests from the decoder
  input  logic                            pop_req_i,
  input  logic                            rd_other_i,

  // pop handshake with the FIFO
  input  logic                            dispatch_event_i,
  input  logic [dispatch_pkg::DATA_W-1:0] dispatch_value_i,
  output logic                            pop_ack_o,

  // read response to the core
  output logic                            rvalid_o,
  output logic [dispatch_pkg::DATA_W-1:0] rdata_o
);

  import dispatch_pkg::*;

  // pop waiting for a value
  logic              pending_q;
  logic              rvalid_q;
  logic [DATA_W-1:0] rdata_q;

  // take the value as soon as it is flagged for this core
  assign pop_ack_o = pending_q & dispatch_event_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
      rvalid_q  <= 1'b0;
    end else begin
      // set one cycle after the request, cleared by the acknowledge
      if (pop_req_i) begin
        pending_q <= 1'b1;
      end else if (pop_ack_o) begin
        pending_q <= 1'b0;
      end

      // one response pulse per read
      rvalid_q <= pop_ack_o | rd_other_i;
    end
  end

  // response data
  always_ff @(posedge clk_i) begin
    if (pop_ack_o) begin
      rdata_q <= dispatch_value_i;
    end else if (rd_other_i) begin
      // other offsets read as zero
      rdata_q <= '0;
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;

endmodule

`default_nettype wire

// ==== verilog/dispatch_unit_top.sv ====
// dispatch unit top level
// register decoder, shared dispatch FIFO and one read responder per core

`timescale 1ns/1ns
`default_nettype none

module dispatch_unit_top (
  input  logic                                                        clk_i,
  input  logic                                                        rst_ni,

  // per-core register bus
  input  logic [dispatch_pkg::NB_CORES-1:0]                           core_req_i,
  input  logic [dispatch_pkg::NB_CORES-1:0]                           core_we_i,
  input  logic [dispatch_pkg::NB_CORES-1:0][dispatch_pkg::ADDR_W-1:0] core_addr_i,
  input  logic [dispatch_pkg::NB_CORES-1:0][dispatch_pkg::DATA_W-1:0] core_wdata_i,
  output logic [dispatch_pkg::NB_CORES-1:0]                           core_rvalid_o,
  output logic [dispatch_pkg::NB_CORES-1:0][dispatch_pkg::DATA_W-1:0] core_rdata_o
);

  import dispatch_pkg::*;

  // decoder to FIFO
  logic [NB_CORES-1:0]             w_req;
  logic [NB_CORES-1:0][ADDR_W-1:0] reg_sel;
  logic [NB_CORES-1:0][DATA_W-1:0] w_data;

  // decoder to responders
  logic [NB_CORES-1:0]             pop_req;
  logic [NB_CORES-1:0]             rd_other;

  // pop handshake
  logic [NB_CORES-1:0]             pop_ack;
  logic [NB_CORES-1:0]             dispatch_event;
  logic [NB_CORES-1:0][DATA_W-1:0] dispatch_value;

  dispatch_reg_decode u_decode (
    .core_req_i   (core_req_i),
    .core_we_i    (core_we_i),
    .core_addr_i  (core_addr_i),
    .core_wdata_i (core_wdata_i),
    .w_req_o      (w_req),
    .reg_sel_o    (reg_sel),
    .w_data_o     (w_data),
    .pop_req_o    (pop_req),
    .rd_other_o   (rd_other)
  );

  dispatch_fifo u_fifo (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .w_req_i          (w_req),
    .reg_sel_i        (reg_sel),
    .w_data_i         (w_data),
    .pop_req_i        (pop_req),
    .pop_ack_i        (pop_ack),
    .dispatch_value_o (dispatch_value),
    .dispatch_event_o (dispatch_event)
  );

  // one responder per core
  for (genvar c = 0; c < NB_CORES; c++) begin : g_resp
    dispatch_read_resp u_resp (
      .clk_i            (clk_i),
      .rst_ni           (rst_ni),
      .pop_req_i        (pop_req[c]),
      .rd_other_i       (rd_other[c]),
      .dispatch_event_i (dispatch_event[c]),
      .dispatch_value_i (dispatch_value[c]),
      .pop_ack_o        (pop_ack[c]),
      .rvalid_o         (core_rvalid_o[c]),
      .rdata_o          (core_rdata_o[c])
    );
  end

endmodule

`default_nettype wire

// ==== verif/dispatch_tb.sv ====
// dispatch unit testbench
// runs a stimulus table through the unit and checks every pop against a
// reference model of the shared FIFO and the per-core read positions

`timescale 1ns/1ns
`default_nettype none

module dispatch_tb;

  import dispatch_pkg::*;

  localparam int CLK_PERIOD  = 40;
  localparam int RST_CYCLES  = 5;
  localparam int DRIVE_DLY   = 5;
  // cycles a held pop must stay unanswered before its push arrives
  localparam int HOLD_CYCLES = 4;
  // worst case for one row including hold and skips
  localparam int ROW_CYCLES  = 16;
  localparam int CORE_W      = $clog2(NB_CORES);

  // Galois LFSR for push data
  localparam logic [31:0] LFSR_SEED = 32'd77005;
  localparam logic [31:0] LFSR_POLY = 32'h80000057;

  // row operations
  localparam logic [1:0] OP_PUSH  = 2'd0;
  localparam logic [1:0] OP_TEAM  = 2'd1;
  localparam logic [1:0] OP_POP   = 2'd2;
  localparam logic [1:0] OP_RDOTH = 2'd3;

  // one stimulus row
  // an exp_lat of zero leaves the latency unchecked
  typedef struct packed {
    logic [CORE_W-1:0] core;
    logic [1:0]        op;
    logic              use_lfsr;
    logic              hold;
    logic [3:0]        exp_lat;
    logic [DATA_W-1:0] data;
  } row_t;

  logic                            clk_i;
  logic                            rst_ni;
  logic [NB_CORES-1:0]             core_req_i;
  logic [NB_CORES-1:0]             core_we_i;
  logic [NB_CORES-1:0][ADDR_W-1:0] core_addr_i;
  logic [NB_CORES-1:0][DATA_W-1:0] core_wdata_i;
  logic [NB_CORES-1:0]             core_rvalid_o;
  logic [NB_CORES-1:0][DATA_W-1:0] core_rdata_o;

  row_t              rows[$];
  logic [31:0]       lfsr_state;
  bit                table_ready;
  longint            watchdog_ns;

  // reference model with entries by absolute push index
  logic [DATA_W-1:0]   model_val[$];
  logic [NB_CORES-1:0] model_mask[$];
  logic [NB_CORES-1:0] model_team;
  int                  model_pos[NB_CORES];

  dispatch_unit_top UUT (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .core_req_i    (core_req_i),
    .core_we_i     (core_we_i),
    .core_addr_i   (core_addr_i),
    .core_wdata_i  (core_wdata_i),
    .core_rvalid_o (core_rvalid_o),
    .core_rdata_o  (core_rdata_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      lfsr_next = (s >> 1) ^ LFSR_POLY;
    end else begin
      lfsr_next = s >> 1;
    end
  endfunction

  // one LFSR step per data bit
  task automatic draw_word(output logic [DATA_W-1:0] w);
    for (int b = 0; b < DATA_W; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      w[b]       = lfsr_state[0];
    end
  endtask

  // oldest entry at or after the core's position that includes the core
  function automatic int find_match(input int c);
    for (int i = model_pos[c]; i < model_val.size(); i++) begin
      if (model_mask[i][c]) begin
        return i;
      end
    end
    return -1;
  endfunction

  task automatic check_value(input logic [DATA_W-1:0] actual, input logic [DATA_W-1:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("mismatch at %0t ns: %s, got 0x%08h, expected 0x%08h",
               $time, what, actual, expected);
      $display("TESTS FAILED");
      $fatal(1, "stopped at the first error");
    end
  endtask

  task automatic stop_run(input string why);
    $display("error at %0t ns: %s", $time, why);
    $display("TESTS FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic add_row(input int core, input int op, input int use_lfsr, input int hold,
                         input int exp_lat, input logic [DATA_W-1:0] data);
    row_t r;
    r.core     = CORE_W'(core);
    r.op       = 2'(op);
    r.use_lfsr = use_lfsr[0];
    r.hold     = hold[0];
    r.exp_lat  = 4'(exp_lat);
    r.data     = data;
    rows.push_back(r);
  endtask

  task automatic build_table();
    // all cores in the team see one value
    add_row(0, OP_TEAM, 0, 0, 0, 32'hF);
    add_row(0, OP_PUSH, 1, 0, 0, '0);
    for (int c = 0; c < NB_CORES; c++) begin
      add_row(c, OP_POP, 0, 0, 2, '0);
    end
    // with partial teams cores 1 and 3 skip the first entry
    add_row(0, OP_TEAM, 0, 0, 0, 32'h5);
    add_row(0, OP_PUSH, 1, 0, 0, '0);
    add_row(0, OP_TEAM, 0, 0, 0, 32'hA);
    add_row(0, OP_PUSH, 1, 0, 0, '0);
    add_row(1, OP_POP, 0, 0, 0, '0);
    add_row(3, OP_POP, 0, 0, 0, '0);
    add_row(0, OP_POP, 0, 0, 2, '0);
    add_row(2, OP_POP, 0, 0, 2, '0);
    // core 3 pops before the matching push
    add_row(0, OP_TEAM, 0, 0, 0, 32'hF);
    add_row(3, OP_POP, 0, 1, 0, '0);
    add_row(0, OP_PUSH, 1, 0, 0, '0);
    add_row(1, OP_POP, 0, 0, 2, '0);
    add_row(0, OP_POP, 0, 0, 0, '0);
    add_row(2, OP_POP, 0, 0, 0, '0);
    // fill the FIFO and let every core drain it in push order
    for (int k = 0; k < FIFO_DEPTH; k++) begin
      add_row(0, OP_PUSH, 1, 0, 0, '0);
    end
    for (int c = 0; c < NB_CORES; c++) begin
      for (int k = 0; k < FIFO_DEPTH; k++) begin
        add_row(c, OP_POP, 0, 0, 2, '0);
      end
    end
    // reads of other offsets followed by pops that show the FIFO untouched
    add_row(1, OP_RDOTH, 0, 0, 1, DATA_W'(REG_PUSH));
    add_row(2, OP_RDOTH, 0, 0, 1, DATA_W'(REG_TEAM));
    add_row(0, OP_PUSH, 0, 0, 0, 32'hC0DE_5A17);
    add_row(1, OP_POP, 0, 0, 2, '0);
    add_row(2, OP_POP, 0, 0, 2, '0);
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #DRIVE_DLY;
  endtask

  // one-cycle bus request on core c
  task automatic issue_access(input int c, input logic we, input logic [ADDR_W-1:0] addr,
                              input logic [DATA_W-1:0] wdata);
    core_req_i[c]   = 1'b1;
    core_we_i[c]    = we;
    core_addr_i[c]  = addr;
    core_wdata_i[c] = wdata;
    next_cycle();
    core_req_i[c]   = 1'b0;
    core_we_i[c]    = 1'b0;
    core_addr_i[c]  = '0;
    core_wdata_i[c] = '0;
  endtask

  task automatic apply_write(input row_t r);
    logic [DATA_W-1:0] wdata;
    if (r.use_lfsr) begin
      draw_word(wdata);
    end else begin
      wdata = r.data;
    end
    if (r.op == OP_TEAM) begin
      issue_access(r.core, 1'b1, REG_TEAM, wdata);
      model_team = wdata[NB_CORES-1:0];
    end else begin
      issue_access(r.core, 1'b1, REG_PUSH, wdata);
      model_val.push_back(wdata);
      model_mask.push_back(model_team);
    end
    // writes get no response
    check_value(DATA_W'(core_rvalid_o), '0, "rvalid after a write");
  endtask

  // latency in cycles from the request, starting at one on entry
  task automatic wait_rvalid(input int c, output int lat);
    lat = 1;
    while (!core_rvalid_o[c]) begin
      next_cycle();
      lat++;
    end
  endtask

  task automatic await_pop(input int c, input int exp_lat);
    int lat;
    int idx;
    wait_rvalid(c, lat);
    idx = find_match(c);
    if (idx < 0) begin
      stop_run($sformatf("core %0d got a value the model does not hold", c));
    end else begin
      if (exp_lat != 0) begin
        check_value(lat, exp_lat, $sformatf("pop latency on core %0d", c));
      end
      check_value(core_rdata_o[c], model_val[idx], $sformatf("pop data on core %0d", c));
      model_pos[c] = idx + 1;
      next_cycle();
      check_value(core_rvalid_o[c], 1'b0, "rvalid held longer than one cycle");
    end
  endtask

  initial begin
    int i;
    int lat;
    int pop_core;
    int pop_lat;
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    core_req_i   = '0;
    core_we_i    = '0;
    core_addr_i  = '0;
    core_wdata_i = '0;
    lfsr_state   = LFSR_SEED;
    model_team   = '0;
    for (int c = 0; c < NB_CORES; c++) begin
      model_pos[c] = 0;
    end
    build_table();
    watchdog_ns = longint'(RST_CYCLES + 4 + rows.size() * ROW_CYCLES) * CLK_PERIOD;
    table_ready = 1'b1;

    repeat (RST_CYCLES) @(posedge clk_i);
    #DRIVE_DLY;
    rst_ni = 1'b1;
    // quiet bus before the first read
    repeat (3) begin
      next_cycle();
      check_value(DATA_W'(core_rvalid_o), '0, "rvalid before any read");
    end

    i = 0;
    while (i < rows.size()) begin
      case (rows[i].op)
        OP_PUSH, OP_TEAM: begin
          apply_write(rows[i]);
        end
        OP_RDOTH: begin
          issue_access(rows[i].core, 1'b0, rows[i].data[ADDR_W-1:0], '0);
          wait_rvalid(rows[i].core, lat);
          check_value(lat, rows[i].exp_lat, "other read latency");
          check_value(core_rdata_o[rows[i].core], '0, "other read data");
          next_cycle();
          check_value(core_rvalid_o[rows[i].core], 1'b0, "other read rvalid too long");
        end
        OP_POP: begin
          pop_core = rows[i].core;
          pop_lat  = rows[i].exp_lat;
          issue_access(pop_core, 1'b0, REG_POP, '0);
          if (rows[i].hold) begin
            // nothing may come back for a blocked pop before the push
            repeat (HOLD_CYCLES) begin
              next_cycle();
              check_value(core_rvalid_o[pop_core], 1'b0, "held pop answered early");
            end
            i++;
            apply_write(rows[i]);
          end
          await_pop(pop_core, pop_lat);
        end
        default: begin
          stop_run("unknown operation in the stimulus table");
        end
      endcase
      i++;
    end

    $display("TESTS PASSED");
    $finish;
  end

  // hang guard sized from the table
  initial begin
    wait (table_ready);
    #(watchdog_ns);
    $display("timeout: the run did not finish within %0d ns", watchdog_ns);
    $display("TESTS FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

// ==== all.f ====
verilog/dispatch_pkg.sv
verilog/dispatch_reg_decode.sv
verilog/dispatch_fifo.sv
verilog/dispatch_read_resp.sv
verilog/dispatch_unit_top.sv
verif/dispatch_tb.sv
